// File: include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// instruction word width
`define DEC_INST_W 16

// general registers r0..r7
`define DEC_NUM_REGS 8

// widest branch offset (BL)
`define DEC_OFF_W 13

// MOVL family immediate
`define DEC_BYTE_W 8

`endif

// File: rtl/decode_pkg.sv
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    typedef logic [`DEC_INST_W-1:0] inst_t;
    typedef logic [$clog2(`DEC_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`DEC_NUM_REGS-1:0] reg_mask_t; // one bit per register

    // OP_NONE must stay at zero, reset value of the output register
    typedef enum logic [5:0] {
        OP_NONE,
        OP_BL,
        OP_BEQ,
        OP_BNE,
        OP_BC,
        OP_BNC,
        OP_BN,
        OP_BGE,
        OP_BLT,
        OP_BRA,
        OP_ADD,   // two-operand alu group
        OP_ADDC,
        OP_SUB,
        OP_SUBC,
        OP_DADD,
        OP_CMP,
        OP_XOR,
        OP_AND,
        OP_OR,
        OP_BIT,
        OP_BIC,
        OP_BIS,
        OP_MOV,
        OP_SWAP,
        OP_SRA,   // single operand group
        OP_RRC,
        OP_COMP,
        OP_SWPB,
        OP_SXT,
        OP_LD,    // memory group
        OP_ST,
        OP_MOVL,
        OP_MOVLZ,
        OP_MOVLS,
        OP_MOVH,
        OP_LDR,
        OP_STR
    } op_e;

    typedef struct packed {
        logic                   rc;   // 1 = constant source
        logic                   wb;   // 1 = byte access
        logic                   prpo; // pre/post address update
        logic                   dec;
        logic                   inc;
        reg_idx_t               s;
        reg_idx_t               d;
        logic [`DEC_OFF_W-1:0]  off;  // zero extended
        logic [`DEC_BYTE_W-1:0] b;
    } operand_fields_t;

    typedef struct packed {
        op_e             op;
        operand_fields_t fields;
        reg_mask_t       set_mask; // registers this instruction writes
        reg_mask_t       dep_mask; // registers it must wait on
    } decode_out_t;

endpackage

`default_nettype wire

// File: rtl/opcode_match.sv
`timescale 1ns/1ns
`default_nettype none

module opcode_match (
    input  wire decode_pkg::inst_t inst,
    output decode_pkg::op_e        op
);

    import decode_pkg::*;

    typedef struct packed {
        inst_t mask;
        inst_t match;
        op_e   op;
    } pattern_t;

    localparam int N_PAT = 36;

    // listed in decode priority, first entry that hits wins
    localparam pattern_t PATTERNS [N_PAT] = '{
        '{16'b1110_0000_0000_0000, 16'b0000_0000_0000_0000, OP_BL},
        '{16'b1111_1100_0000_0000, 16'b0010_0000_0000_0000, OP_BEQ},
        '{16'b1111_1100_0000_0000, 16'b0010_0100_0000_0000, OP_BNE},
        '{16'b1111_1100_0000_0000, 16'b0010_1000_0000_0000, OP_BC},
        '{16'b1111_1100_0000_0000, 16'b0010_1100_0000_0000, OP_BNC},
        '{16'b1111_1100_0000_0000, 16'b0011_0000_0000_0000, OP_BN},
        '{16'b1111_1100_0000_0000, 16'b0011_0100_0000_0000, OP_BGE},
        '{16'b1111_1100_0000_0000, 16'b0011_1000_0000_0000, OP_BLT},
        '{16'b1111_1100_0000_0000, 16'b0011_1100_0000_0000, OP_BRA},
        '{16'b1111_1111_0000_0000, 16'b0100_0000_0000_0000, OP_ADD},
        '{16'b1111_1111_0000_0000, 16'b0100_0001_0000_0000, OP_ADDC},
        '{16'b1111_1111_0000_0000, 16'b0100_0010_0000_0000, OP_SUB},
        '{16'b1111_1111_0000_0000, 16'b0100_0011_0000_0000, OP_SUBC},
        '{16'b1111_1111_0000_0000, 16'b0100_0100_0000_0000, OP_DADD},
        '{16'b1111_1111_0000_0000, 16'b0100_0101_0000_0000, OP_CMP},
        '{16'b1111_1111_0000_0000, 16'b0100_0110_0000_0000, OP_XOR},
        '{16'b1111_1111_0000_0000, 16'b0100_0111_0000_0000, OP_AND},
        '{16'b1111_1111_0000_0000, 16'b0100_1000_0000_0000, OP_OR},
        '{16'b1111_1111_0000_0000, 16'b0100_1001_0000_0000, OP_BIT},
        '{16'b1111_1111_0000_0000, 16'b0100_1010_0000_0000, OP_BIC},
        '{16'b1111_1111_0000_0000, 16'b0100_1011_0000_0000, OP_BIS},
        '{16'b1111_1111_1000_0000, 16'b0100_1100_0000_0000, OP_MOV},
        '{16'b1111_1111_1000_0000, 16'b0100_1100_1000_0000, OP_SWAP},
        // bit 6 is wb, left out of the single operand masks
        '{16'b1111_1111_1011_1000, 16'b0100_1101_0000_0000, OP_SRA},
        '{16'b1111_1111_1011_1000, 16'b0100_1101_0000_1000, OP_RRC},
        '{16'b1111_1111_1011_1000, 16'b0100_1101_0001_0000, OP_COMP},
        '{16'b1111_1111_1011_1000, 16'b0100_1101_0001_1000, OP_SWPB},
        '{16'b1111_1111_1011_1000, 16'b0100_1101_0010_0000, OP_SXT},
        '{16'b1111_1100_0000_0000, 16'b0101_1000_0000_0000, OP_LD},
        '{16'b1111_1100_0000_0000, 16'b0101_1100_0000_0000, OP_ST},
        '{16'b1111_1000_0000_0000, 16'b0110_0000_0000_0000, OP_MOVL},
        '{16'b1111_1000_0000_0000, 16'b0110_1000_0000_0000, OP_MOVLZ},
        '{16'b1111_1000_0000_0000, 16'b0111_0000_0000_0000, OP_MOVLS},
        '{16'b1111_1000_0000_0000, 16'b0111_1000_0000_0000, OP_MOVH},
        '{16'b1100_0000_0000_0000, 16'b1000_0000_0000_0000, OP_LDR},
        '{16'b1100_0000_0000_0000, 16'b1100_0000_0000_0000, OP_STR}
    };

    always_comb begin
        op = OP_NONE; // unknown encodings fall through to this
        // walk from the back so the lowest index is written last
        for (int i = N_PAT - 1; i >= 0; i--) begin
            if ((inst & PATTERNS[i].mask) == PATTERNS[i].match) begin
                op = PATTERNS[i].op;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/operand_extract.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_config.svh"

module operand_extract (
    input  wire decode_pkg::inst_t     inst,
    input  wire decode_pkg::op_e       op,
    output decode_pkg::operand_fields_t fields
);

    import decode_pkg::*;

    always_comb begin
        fields = '0; // fields an opcode does not use stay zero
        case (op)
            OP_BL: begin
                fields.off = `DEC_OFF_W'(inst[12:0]);
            end
            OP_BEQ, OP_BNE, OP_BC, OP_BNC,
            OP_BN, OP_BGE, OP_BLT, OP_BRA: begin
                fields.off = `DEC_OFF_W'(inst[9:0]); // 10 bit branch offset
            end
            OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD, OP_CMP,
            OP_XOR, OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS: begin
                fields.rc = inst[7];
                fields.wb = inst[6];
                fields.s  = inst[5:3];
                fields.d  = inst[2:0];
            end
            OP_MOV: begin
                fields.wb = inst[6];
                fields.s  = inst[5:3];
                fields.d  = inst[2:0];
            end
            OP_SWAP: begin
                fields.s = inst[5:3];
                fields.d = inst[2:0];
            end
            OP_SRA, OP_RRC, OP_COMP: begin
                fields.wb = inst[6];
                fields.d  = inst[2:0];
            end
            OP_SWPB, OP_SXT: begin
                fields.d = inst[2:0]; // always word sized
            end
            OP_LD, OP_ST: begin
                fields.prpo = inst[9];
                fields.dec  = inst[8];
                fields.inc  = inst[7];
                fields.wb   = inst[6];
                fields.s    = inst[5:3];
                fields.d    = inst[2:0];
            end
            OP_MOVL, OP_MOVLZ, OP_MOVLS, OP_MOVH: begin
                fields.b = inst[10:3];
                fields.d = inst[2:0];
            end
            OP_LDR, OP_STR: begin
                fields.off = `DEC_OFF_W'(inst[12:7]); // 6 bit displacement
                fields.wb  = inst[6];
                fields.s   = inst[5:3];
                fields.d   = inst[2:0];
            end
            default: begin
                fields = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dependency_mask.sv
`timescale 1ns/1ns
`default_nettype none

module dependency_mask (
    input  wire decode_pkg::op_e             op,
    input  wire decode_pkg::operand_fields_t fields,
    output decode_pkg::reg_mask_t            set_mask,
    output decode_pkg::reg_mask_t            dep_mask
);

    import decode_pkg::*;

    reg_mask_t s_bit;   // one-hot of source register
    reg_mask_t d_bit;   // one-hot of destination register
    reg_mask_t alu_dep;

    assign s_bit = reg_mask_t'(1) << fields.s;
    assign d_bit = reg_mask_t'(1) << fields.d;

    // a constant source carries no register dependency
    assign alu_dep = fields.rc ? d_bit : (d_bit | s_bit);

    always_comb begin
        set_mask = '0; // branches and OP_NONE touch no registers
        dep_mask = '0;
        case (op)
            OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD,
            OP_XOR, OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS: begin
                dep_mask = alu_dep;
                set_mask = d_bit;
            end
            OP_CMP: begin
                dep_mask = alu_dep; // flags only, nothing written
            end
            OP_MOV: begin
                dep_mask = s_bit | d_bit;
                set_mask = d_bit;
            end
            OP_SWAP, OP_LD, OP_LDR: begin
                dep_mask = s_bit | d_bit;
                set_mask = s_bit | d_bit; // s is the address reg, may update
            end
            OP_SRA, OP_RRC, OP_COMP, OP_SWPB, OP_SXT: begin
                dep_mask = d_bit;
                set_mask = d_bit;
            end
            OP_ST, OP_STR: begin
                dep_mask = s_bit | d_bit;
            end
            OP_MOVL, OP_MOVLZ, OP_MOVLS, OP_MOVH: begin
                set_mask = d_bit; // byte loads read no register
            end
            default: begin
                set_mask = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire decode_pkg::inst_t  inst,
    input  wire                     inst_valid,
    output decode_pkg::decode_out_t dec,
    output logic                    dec_valid
);

    import decode_pkg::*;

    op_e             op;
    operand_fields_t fields;
    reg_mask_t       set_mask;
    reg_mask_t       dep_mask;
    decode_out_t     dec_next;

    opcode_match u_opcode_match (
        .inst (inst),
        .op   (op)
    );

    operand_extract u_operand_extract (
        .inst   (inst),
        .op     (op),
        .fields (fields)
    );

    dependency_mask u_dependency_mask (
        .op       (op),
        .fields   (fields),
        .set_mask (set_mask),
        .dep_mask (dep_mask)
    );

    assign dec_next = '{
        op:       op,
        fields:   fields,
        set_mask: set_mask,
        dep_mask: dep_mask
    };

    // one clock of latency, a new word can enter every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec       <= '0; // op reads OP_NONE
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                dec <= dec_next; // hold last record otherwise
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_config.svh"

module tb_decode_stage;

    import decode_pkg::*;

    typedef struct packed {
        inst_t       inst;
        decode_out_t exp;
    } vec_t;

    logic        clk;
    logic        rst_n;
    inst_t       inst;
    logic        inst_valid;
    decode_out_t dec;
    logic        dec_valid;

    vec_t  vecs[$];
    string names[$];
    int    tests;
    int    errors;
    int    seed;

    decode_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dec_valid  (dec_valid)
    );

    always #5 clk = ~clk;

    // flags are {rc, wb, prpo, dec, inc}
    function automatic operand_fields_t make_fields(logic [4:0] flags, reg_idx_t s, reg_idx_t d,
                                                    logic [`DEC_OFF_W-1:0] off,
                                                    logic [`DEC_BYTE_W-1:0] b);
        return operand_fields_t'({flags, s, d, off, b});
    endfunction

    task automatic add_vec(string name, inst_t w, op_e op, operand_fields_t f,
                           reg_mask_t set_m, reg_mask_t dep_m);
        vec_t v;
        v.inst         = w;
        v.exp.op       = op;
        v.exp.fields   = f;
        v.exp.set_mask = set_m;
        v.exp.dep_mask = dep_m;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    // expected record straight from the field and mask tables
    function automatic decode_out_t expected_record(op_e op, inst_t w);
        decode_out_t e;
        reg_mask_t   sb;
        reg_mask_t   db;
        e    = '0;
        e.op = op;
        if (op == OP_BL) begin
            e.fields.off = w[12:0];
        end else if (op inside {[OP_BEQ:OP_BRA]}) begin
            e.fields.off = `DEC_OFF_W'(w[9:0]);
        end else if (op inside {[OP_MOVL:OP_MOVH]}) begin
            e.fields.b = w[10:3];
            e.fields.d = w[2:0];
        end else if (op != OP_NONE) begin
            e.fields.d = w[2:0]; // every register group has d
            if (!(op inside {[OP_SRA:OP_SXT]})) e.fields.s = w[5:3];
            if (!(op inside {OP_SWAP, OP_SWPB, OP_SXT})) e.fields.wb = w[6];
            if (op inside {[OP_ADD:OP_BIS]}) e.fields.rc = w[7];
            if (op inside {OP_LD, OP_ST}) {e.fields.prpo, e.fields.dec, e.fields.inc} = w[9:7];
            if (op inside {OP_LDR, OP_STR}) e.fields.off = `DEC_OFF_W'(w[12:7]);
        end
        sb = reg_mask_t'(1) << e.fields.s;
        db = reg_mask_t'(1) << e.fields.d;
        if (op inside {[OP_ADD:OP_BIS]}) begin
            e.dep_mask = e.fields.rc ? db : (db | sb);
            e.set_mask = (op == OP_CMP) ? '0 : db;
        end else if (op inside {OP_MOV, OP_SWAP, OP_LD, OP_LDR, OP_ST, OP_STR}) begin
            e.dep_mask = sb | db;
            if (op == OP_MOV) e.set_mask = db;
            if (op inside {OP_SWAP, OP_LD, OP_LDR}) e.set_mask = sb | db;
        end else if (op inside {[OP_SRA:OP_SXT]}) begin
            e.dep_mask = db;
            e.set_mask = db;
        end else if (op inside {[OP_MOVL:OP_MOVH]}) begin
            e.set_mask = db;
        end
        return e;
    endfunction

    // random word from one of the kept groups and its opcode
    task automatic random_word(output inst_t w, output op_e op);
        logic [31:0] r;
        logic [3:0]  k;
        logic [2:0]  j;
        logic [21:0] pair;
        r = $random(seed);
        k = 4'(r[19:16] % 4'd12);
        j = 3'(r[18:16] % 3'd5);
        case (r[23:21])
            3'd0: pair = {3'b000, r[12:0], OP_BL};
            3'd1: pair = {3'b001, r[12:0], 6'(OP_BEQ + r[12:10])};
            3'd2: pair = {4'b0100, k, r[7:0], 6'(OP_ADD + k)};
            3'd3: pair = {8'h4c, r[7:0], r[7] ? OP_SWAP : OP_MOV};
            3'd4: pair = {8'h4d, 1'b0, r[6], j, r[2:0], 6'(OP_SRA + j)};
            3'd5: pair = {5'b01011, r[10:0], r[10] ? OP_ST : OP_LD};
            3'd6: pair = {3'b011, r[12:0], 6'(OP_MOVL + r[12:11])};
            default: pair = {1'b1, r[14:0], r[14] ? OP_STR : OP_LDR};
        endcase
        w  = pair[21:6];
        op = op_e'(pair[5:0]);
    endtask

    task automatic wait_valid(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 10) begin
            @(negedge clk); // sample away from the active edge
            seen = dec_valid;
            n++;
        end
        if (!seen) begin
            $display("timeout at %0t: dec_valid never arrived within 10 cycles", $time);
            errors++;
            tests++;
        end
    endtask

    task automatic check_record(string name, decode_out_t exp, logic exp_valid);
        logic ok;
        ok = 1'b1;
        assert (dec_valid === exp_valid) else begin
            $display("CHECK FAILED at %0t: %s dec_valid %b, expected %b",
                     $time, name, dec_valid, exp_valid);
            ok = 1'b0;
        end
        assert (dec.op === exp.op) else begin
            $display("CHECK FAILED at %0t: %s op %0d, expected %0d", $time, name, dec.op, exp.op);
            ok = 1'b0;
        end
        assert (dec.fields === exp.fields) else begin
            $display("CHECK FAILED at %0t: %s fields %h, expected %h",
                     $time, name, dec.fields, exp.fields);
            ok = 1'b0;
        end
        assert ({dec.set_mask, dec.dep_mask} === {exp.set_mask, exp.dep_mask}) else begin
            $display("CHECK FAILED at %0t: %s set/dep %h/%h, expected %h/%h", $time, name,
                     dec.set_mask, dec.dep_mask, exp.set_mask, exp.dep_mask);
            ok = 1'b0;
        end
        tests++;
        if (!ok) errors++;
        $display("%s: %s", name, ok ? "pass" : "mismatch");
    endtask

    task automatic run_vec(string name, vec_t v);
        logic seen;
        @(posedge clk);
        inst       <= v.inst;
        inst_valid <= 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0; // single strobe
        wait_valid(seen);
        if (seen) check_record(name, v.exp, 1'b1);
    endtask

    task automatic build_table();
        add_vec("BL", 16'h1abc, OP_BL, make_fields(5'b0, 3'd0, 3'd0, 13'h1abc, 8'h0), 8'h0, 8'h0);
        add_vec("BEQ", 16'h2155, OP_BEQ, make_fields(5'b0, 3'd0, 3'd0, 13'h155, 8'h0), 8'h0, 8'h0);
        add_vec("BNE", 16'h27ff, OP_BNE, make_fields(5'b0, 3'd0, 3'd0, 13'h3ff, 8'h0), 8'h0, 8'h0);
        add_vec("BC", 16'h2801, OP_BC, make_fields(5'b0, 3'd0, 3'd0, 13'h001, 8'h0), 8'h0, 8'h0);
        add_vec("BNC", 16'h2e00, OP_BNC, make_fields(5'b0, 3'd0, 3'd0, 13'h200, 8'h0), 8'h0, 8'h0);
        add_vec("BN", 16'h3010, OP_BN, make_fields(5'b0, 3'd0, 3'd0, 13'h010, 8'h0), 8'h0, 8'h0);
        add_vec("BGE", 16'h3444, OP_BGE, make_fields(5'b0, 3'd0, 3'd0, 13'h044, 8'h0), 8'h0, 8'h0);
        add_vec("BLT", 16'h3bfe, OP_BLT, make_fields(5'b0, 3'd0, 3'd0, 13'h3fe, 8'h0), 8'h0, 8'h0);
        add_vec("BRA", 16'h3c07, OP_BRA, make_fields(5'b0, 3'd0, 3'd0, 13'h007, 8'h0), 8'h0, 8'h0);
        add_vec("ADD rc0", 16'h405d, OP_ADD, make_fields(5'b01000, 3'd3, 3'd5, 13'h0, 8'h0),
                8'h20, 8'h28);
        add_vec("ADD rc1", 16'h4096, OP_ADD, make_fields(5'b10000, 3'd2, 3'd6, 13'h0, 8'h0),
                8'h40, 8'h40);
        add_vec("CMP", 16'h450f, OP_CMP, make_fields(5'b0, 3'd1, 3'd7, 13'h0, 8'h0), 8'h0, 8'h82);
        add_vec("MOV", 16'h4c60, OP_MOV, make_fields(5'b01000, 3'd4, 3'd0, 13'h0, 8'h0),
                8'h01, 8'h11);
        add_vec("SWAP", 16'h4cf9, OP_SWAP, make_fields(5'b0, 3'd7, 3'd1, 13'h0, 8'h0),
                8'h82, 8'h82);
        add_vec("SXT", 16'h4d63, OP_SXT, make_fields(5'b0, 3'd0, 3'd3, 13'h0, 8'h0), 8'h08, 8'h08);
        add_vec("LD", 16'h5a94, OP_LD, make_fields(5'b00101, 3'd2, 3'd4, 13'h0, 8'h0),
                8'h14, 8'h14);
        add_vec("ST", 16'h5d76, OP_ST, make_fields(5'b01010, 3'd6, 3'd6, 13'h0, 8'h0), 8'h0, 8'h40);
        add_vec("MOVLZ", 16'h6d2a, OP_MOVLZ, make_fields(5'b0, 3'd0, 3'd2, 13'h0, 8'ha5),
                8'h04, 8'h0);
        add_vec("LDR", 16'h95e9, OP_LDR, make_fields(5'b01000, 3'd5, 3'd1, 13'h02b, 8'h0),
                8'h22, 8'h22);
        add_vec("STR", 16'he087, OP_STR, make_fields(5'b0, 3'd0, 3'd7, 13'h001, 8'h0), 8'h0, 8'h81);
        // removed instructions decode to nothing
        add_vec("SETPRI", 16'h5000, OP_NONE, '0, 8'h0, 8'h0);
        add_vec("SVC", 16'h5088, OP_NONE, '0, 8'h0, 8'h0);
        add_vec("SETCC", 16'h5210, OP_NONE, '0, 8'h0, 8'h0);
        add_vec("CLRCC", 16'h5418, OP_NONE, '0, 8'h0, 8'h0);
        add_vec("CEX", 16'h5342, OP_NONE, '0, 8'h0, 8'h0);
        add_vec("unused 4d", 16'h4d2a, OP_NONE, '0, 8'h0, 8'h0);
    endtask

    initial begin
        int    burst[3];
        vec_t  v;
        inst_t w;
        op_e   op;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        seed       = 17;
        tests      = 0;
        errors     = 0;
        burst      = '{9, 15, 19}; // ADD, LD, STR
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_record("after reset", '0, 1'b0);

        for (int i = 0; i < vecs.size(); i++) begin
            run_vec(names[i], vecs[i]);
        end

        // three strobes in a row followed by one idle cycle
        for (int i = 0; i <= 3; i++) begin
            @(posedge clk);
            if (i < 3) begin
                inst       <= vecs[burst[i]].inst;
                inst_valid <= 1'b1;
            end else begin
                inst       <= vecs[0].inst; // new word without a strobe
                inst_valid <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                check_record({"burst ", names[burst[i-1]]}, vecs[burst[i-1]].exp, 1'b1);
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_record("idle hold", vecs[burst[2]].exp, 1'b0);

        for (int i = 0; i < 20; i++) begin
            random_word(w, op);
            v.inst = w;
            v.exp  = expected_record(op, w);
            run_vec($sformatf("random %0d %h", i, w), v);
        end

        $display("tests run: %0d, failing: %0d", tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_stage.f
+incdir+include
rtl/decode_pkg.sv
rtl/opcode_match.sv
rtl/operand_extract.sv
rtl/dependency_mask.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_decode_stage -f decode_stage.f

output=$(./obj_dir/Vtb_decode_stage)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
